//--- verilog/rv_csr_pkg.sv
/*
 * Architectural view of the RV32 machine-mode CSRs.
 * Holds the CSR address map, the mstatus and mcause field positions and
 * the union used to take apart a word written to a CSR.
 */
package rv_csr_pkg;

    // One CSR address as carried by the CSR access port.
    typedef logic [11:0] csr_addr_t;

    // Machine trap setup.
    localparam csr_addr_t csr_mstatus    = 12'h300;
    localparam csr_addr_t csr_misa       = 12'h301;
    localparam csr_addr_t csr_medeleg    = 12'h302;
    localparam csr_addr_t csr_mideleg    = 12'h303;
    localparam csr_addr_t csr_mie        = 12'h304;
    localparam csr_addr_t csr_mtvec      = 12'h305;
    localparam csr_addr_t csr_mstatush   = 12'h310;
    // Machine trap handling.
    localparam csr_addr_t csr_mscratch   = 12'h340;
    localparam csr_addr_t csr_mepc       = 12'h341;
    localparam csr_addr_t csr_mcause     = 12'h342;
    localparam csr_addr_t csr_mtval      = 12'h343;
    localparam csr_addr_t csr_mip        = 12'h344;
    // Machine information, all read-only.
    localparam csr_addr_t csr_mvendorid  = 12'hf11;
    localparam csr_addr_t csr_marchid    = 12'hf12;
    localparam csr_addr_t csr_mimpid     = 12'hf13;
    localparam csr_addr_t csr_mhartid    = 12'hf14;
    localparam csr_addr_t csr_mconfigptr = 12'hf15;

    // Field positions.
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mcause_int_bit   = 31;

    // Write word, seen raw, as mstatus or as mcause.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [31:8] rsvd_hi;
            logic        mpie;
            logic [6:4]  rsvd_mid;
            logic        mie;
            logic [2:0]  rsvd_lo;
        } mstatus;
        struct packed {
            logic        interrupt;
            logic [30:5] rsvd;
            logic [4:0]  cause;
        } mcause;
    } csr_wdata_u;

endpackage

//--- verilog/trap_cfg_pkg.sv
/*
 * Implementation constants of the trap unit.
 * Widths, the external interrupt range and fixed CSR read values.
 */
package trap_cfg_pkg;

    // Data width of the core.
    localparam int xlen = 32;

    // Cause number as held in mcause.
    localparam int cause_w = 5;

    // Trap code as delivered by the pipeline.
    localparam int trap_cause_w = 4;

    // First external interrupt line, upper half of mip.
    localparam int irq_first = 16;

    // RV32IM, MXL = 1, I and M extension bits set.
    localparam logic [31:0] misa_value = 32'h4000_1100;

endpackage

//--- verilog/irq_arbiter.sv
/*
 * External interrupt latch and fixed-priority selector.
 * Registers the irq lines into their mip positions, masks them with mie
 * and returns the lowest pending number, or zero when none is pending.
 */
`timescale 1ns/1ps

module irq_arbiter #(
    parameter int irq_lo = trap_cfg_pkg::irq_first
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [trap_cfg_pkg::xlen-1:irq_lo] irq,
    input  logic [trap_cfg_pkg::xlen-1:0]    mie,
    output logic [trap_cfg_pkg::xlen-1:0]    irq_pending_masked,
    output logic [trap_cfg_pkg::cause_w-1:0] irq_cause
);

    // Latched lines, low bits stay zero.
    logic [trap_cfg_pkg::xlen-1:0] irq_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= '0;
        end else begin
            irq_pending                               <= '0;
            irq_pending[trap_cfg_pkg::xlen-1:irq_lo] <= irq;
        end
    end

    // This is what mip reads back.
    assign irq_pending_masked = irq_pending & mie;

    // Scan downwards so the lowest set bit is the last one to win.
    always_comb begin
        irq_cause = '0;
        for (int i = trap_cfg_pkg::xlen - 1; i >= irq_lo; i--) begin
            if (irq_pending_masked[i]) begin
                irq_cause = i[trap_cfg_pkg::cause_w-1:0];
            end
        end
    end

endmodule

//--- verilog/trap_dispatch.sv
/*
 * Chooses between an interrupt and a pipeline trap each cycle.
 * Interrupts rank above traps; the selected cause and PC go to the
 * CSR file to be saved at the next edge.
 */
`timescale 1ns/1ps

module trap_dispatch (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [trap_cfg_pkg::cause_w-1:0]      irq_cause,
    input  logic                                  mstatus_mie,
    input  logic                                  insn_valid,
    input  logic [31:1]                           insn_pc,
    input  logic                                  trap,
    input  logic [trap_cfg_pkg::trap_cause_w-1:0] trap_cause,
    input  logic [31:1]                           trap_pc,
    output logic                                  take_irq,
    output logic                                  take_trap,
    output logic [trap_cfg_pkg::cause_w-1:0]      save_cause,
    output logic [31:1]                           save_pc
);

    localparam int pad_w = trap_cfg_pkg::cause_w - trap_cfg_pkg::trap_cause_w;

    // MIE as it was one cycle ago.
    logic mie_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_prev <= 1'b0;
        end else begin
            mie_prev <= mstatus_mie;
        end
    end

    // Needs MIE high for two cycles running.
    // Gives the handler one instruction after re-enabling.
    assign take_irq = (irq_cause != '0) && insn_valid && mstatus_mie && mie_prev;

    // A trap only goes through when no interrupt claims the cycle.
    assign take_trap = trap && !take_irq;

    always_comb begin
        if (take_irq) begin
            save_cause = irq_cause;
            save_pc    = insn_pc;
        end else begin
            // Trap code zero-extended to the mcause width.
            save_cause = {{pad_w{1'b0}}, trap_cause};
            save_pc    = trap_pc;
        end
    end

endmodule

//--- verilog/csr_file.sv
/*
 * Machine-mode CSR storage with combinational read decode.
 * Updated at each edge by reset, MRET, a taken exception or a CSR write,
 * in that order of priority.
 */
`timescale 1ns/1ps

module csr_file #(
    parameter logic [31:0] hartid = 32'h0000_0000
) (
    input  logic                             clk,
    input  logic                             rst,
    input  rv_csr_pkg::csr_addr_t            csr_addr,
    input  logic                             csr_we,
    input  logic [trap_cfg_pkg::xlen-1:0]    csr_wdata,
    input  logic [trap_cfg_pkg::xlen-1:0]    irq_pending_masked,
    input  logic                             take_irq,
    input  logic                             take_trap,
    input  logic [trap_cfg_pkg::cause_w-1:0] save_cause,
    input  logic [31:1]                      save_pc,
    input  logic                             mret,
    output logic [trap_cfg_pkg::xlen-1:0]    csr_rdata,
    output logic                             csr_exists,
    output logic                             csr_rdonly,
    output logic [trap_cfg_pkg::xlen-1:0]    mie,
    output logic                             mstatus_mie,
    output logic [31:2]                      trap_vector,
    output logic [31:1]                      ret_epc
);

    // Stored state.
    logic                             mstatus_mpie;
    logic [31:2]                      mtvec;
    logic [trap_cfg_pkg::xlen-1:0]    mscratch;
    logic [31:1]                      mepc;
    logic                             mcause_int;
    logic [trap_cfg_pkg::cause_w-1:0] mcause_no;

    // Written word split into its field views.
    rv_csr_pkg::csr_wdata_u wdata_u;

    // Read-back words built from the fields.
    logic [trap_cfg_pkg::xlen-1:0] mstatus_rd;
    logic [trap_cfg_pkg::xlen-1:0] mcause_rd;

    assign wdata_u.raw = csr_wdata;
    assign trap_vector = mtvec;
    assign ret_epc     = mepc;

    always_comb begin
        mstatus_rd                               = '0;
        mstatus_rd[rv_csr_pkg::mstatus_mie_bit]  = mstatus_mie;
        mstatus_rd[rv_csr_pkg::mstatus_mpie_bit] = mstatus_mpie;
        mcause_rd                                = '0;
        mcause_rd[rv_csr_pkg::mcause_int_bit]    = mcause_int;
        mcause_rd[trap_cfg_pkg::cause_w-1:0]     = mcause_no;
    end

    // Read decode.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        csr_rdata  = '0;
        case (csr_addr)
            rv_csr_pkg::csr_mstatus:  csr_rdata = mstatus_rd;
            rv_csr_pkg::csr_misa:     csr_rdata = trap_cfg_pkg::misa_value;
            rv_csr_pkg::csr_mie:      csr_rdata = mie;
            rv_csr_pkg::csr_mtvec:    csr_rdata = {mtvec, 2'b00};
            rv_csr_pkg::csr_mip:      csr_rdata = irq_pending_masked;
            rv_csr_pkg::csr_mscratch: csr_rdata = mscratch;
            rv_csr_pkg::csr_mepc:     csr_rdata = {mepc, 1'b0};
            rv_csr_pkg::csr_mcause:   csr_rdata = mcause_rd;
            // No delegation, no high status half, no trap value.
            rv_csr_pkg::csr_medeleg,
            rv_csr_pkg::csr_mideleg,
            rv_csr_pkg::csr_mstatush,
            rv_csr_pkg::csr_mtval:    csr_rdata = '0;
            // Identification block.
            rv_csr_pkg::csr_mhartid: begin
                csr_rdonly = 1'b1;
                csr_rdata  = hartid;
            end
            rv_csr_pkg::csr_mvendorid,
            rv_csr_pkg::csr_marchid,
            rv_csr_pkg::csr_mimpid,
            rv_csr_pkg::csr_mconfigptr: begin
                csr_rdonly = 1'b1;
            end
            default: begin
                csr_exists = 1'b0;
            end
        endcase
    end

    // Update.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_no    <= '0;
        end else if (mret) begin
            // Return restores the enable saved on entry.
            mstatus_mie <= mstatus_mpie;
        end else if (take_irq || take_trap) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mepc         <= save_pc;
            mcause_int   <= take_irq;
            mcause_no    <= save_cause;
        end else if (csr_we && csr_exists && !csr_rdonly) begin
            // Constant CSRs fall through and ignore the write.
            case (csr_addr)
                rv_csr_pkg::csr_mstatus: begin
                    mstatus_mie  <= wdata_u.mstatus.mie;
                    mstatus_mpie <= wdata_u.mstatus.mpie;
                end
                rv_csr_pkg::csr_mie:      mie      <= wdata_u.raw;
                rv_csr_pkg::csr_mtvec:    mtvec    <= wdata_u.raw[31:2];
                rv_csr_pkg::csr_mscratch: mscratch <= wdata_u.raw;
                rv_csr_pkg::csr_mepc:     mepc     <= wdata_u.raw[31:1];
                rv_csr_pkg::csr_mcause: begin
                    mcause_int <= wdata_u.mcause.interrupt;
                    mcause_no  <= wdata_u.mcause.cause;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- verilog/trap_unit_top.sv
/*
 * Machine-mode trap and CSR unit of a small RV32 core.
 * Connects the interrupt arbiter, the trap dispatcher and the CSR file.
 * The pipeline drives the trap, MRET and CSR access strobes directly.
 */
`timescale 1ns/1ps

module trap_unit_top #(
    parameter logic [31:0] hartid = 32'h0000_0000,
    parameter int          irq_lo = trap_cfg_pkg::irq_first
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [31:irq_lo]                      irq,
    input  rv_csr_pkg::csr_addr_t                 csr_addr,
    input  logic                                  csr_we,
    input  logic [trap_cfg_pkg::xlen-1:0]         csr_wdata,
    output logic [trap_cfg_pkg::xlen-1:0]         csr_rdata,
    output logic                                  csr_exists,
    output logic                                  csr_rdonly,
    input  logic                                  trap,
    input  logic [trap_cfg_pkg::trap_cause_w-1:0] trap_cause,
    input  logic [31:1]                           trap_pc,
    input  logic                                  insn_valid,
    input  logic [31:1]                           insn_pc,
    input  logic                                  mret,
    output logic                                  exception,
    output logic [31:2]                           trap_vector,
    output logic [31:1]                           ret_epc
);

    logic [trap_cfg_pkg::xlen-1:0]    irq_pending_masked;
    logic [trap_cfg_pkg::cause_w-1:0] irq_cause;
    logic [trap_cfg_pkg::xlen-1:0]    mie;
    logic                             mstatus_mie;
    logic                             take_irq;
    logic                             take_trap;
    logic [trap_cfg_pkg::cause_w-1:0] save_cause;
    logic [31:1]                      save_pc;

    // Redirect request to the fetch stage.
    assign exception = take_irq | take_trap;

    irq_arbiter #(
        .irq_lo (irq_lo)
    ) u_irq_arbiter (
        .clk                (clk),
        .rst                (rst),
        .irq                (irq),
        .mie                (mie),
        .irq_pending_masked (irq_pending_masked),
        .irq_cause          (irq_cause)
    );

    trap_dispatch u_trap_dispatch (
        .clk         (clk),
        .rst         (rst),
        .irq_cause   (irq_cause),
        .mstatus_mie (mstatus_mie),
        .insn_valid  (insn_valid),
        .insn_pc     (insn_pc),
        .trap        (trap),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .take_irq    (take_irq),
        .take_trap   (take_trap),
        .save_cause  (save_cause),
        .save_pc     (save_pc)
    );

    csr_file #(
        .hartid (hartid)
    ) u_csr_file (
        .clk                (clk),
        .rst                (rst),
        .csr_addr           (csr_addr),
        .csr_we             (csr_we),
        .csr_wdata          (csr_wdata),
        .irq_pending_masked (irq_pending_masked),
        .take_irq           (take_irq),
        .take_trap          (take_trap),
        .save_cause         (save_cause),
        .save_pc            (save_pc),
        .mret               (mret),
        .csr_rdata          (csr_rdata),
        .csr_exists         (csr_exists),
        .csr_rdonly         (csr_rdonly),
        .mie                (mie),
        .mstatus_mie        (mstatus_mie),
        .trap_vector        (trap_vector),
        .ret_epc            (ret_epc)
    );

endmodule

//--- sim/trap_unit_checker.sv
/*
 * Concurrent assertions on the trap unit, bound into trap_unit_top.
 * Covers reset quiet time, vector alignment and interrupt gating.
 */
`timescale 1ns/1ps

module trap_unit_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  exception,
    input logic                  insn_valid,
    input logic                  take_irq,
    input rv_csr_pkg::csr_addr_t csr_addr,
    input logic [31:0]           csr_rdata,
    input logic [31:2]           trap_vector
);

    // Nothing is taken while reset is held.
    no_exception_in_reset: assert property (@(posedge clk) rst |-> !exception)
        else $error("exception raised during reset");

    // mtvec reads back the vector with zero low bits.
    vector_aligned: assert property (@(posedge clk) disable iff (rst)
        (csr_addr == rv_csr_pkg::csr_mtvec) |-> (csr_rdata == {trap_vector, 2'b00}))
        else $error("mtvec read differs from the word-aligned trap vector");

    // Interrupts only land on a valid instruction.
    irq_needs_insn: assert property (@(posedge clk) disable iff (rst)
        !insn_valid |-> !take_irq)
        else $error("interrupt taken without a valid instruction");

endmodule

bind trap_unit_top trap_unit_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .exception   (exception),
    .insn_valid  (insn_valid),
    .take_irq    (take_irq),
    .csr_addr    (csr_addr),
    .csr_rdata   (csr_rdata),
    .trap_vector (trap_vector)
);

//--- sim/trap_unit_tb.sv
/*
 * Directed testbench for the machine-mode trap and CSR unit.
 * Drives CSR accesses, traps, interrupts and MRET on the falling edge
 * and checks the read-back state against the architectural rules.
 */
`timescale 1ns/1ps

module trap_unit_tb;

    localparam logic [31:0] hart_id = 32'h0000_0005;
    localparam int          irq_lo  = trap_cfg_pkg::irq_first;

    // Rough sum of all test lengths in cycles.
    localparam int test_budget    = 200;
    localparam int timeout_cycles = 2 * test_budget;

    logic                                  clk;
    logic                                  rst;
    logic [31:irq_lo]                      irq;
    rv_csr_pkg::csr_addr_t                 csr_addr;
    logic                                  csr_we;
    logic [31:0]                           csr_wdata;
    logic [31:0]                           csr_rdata;
    logic                                  csr_exists;
    logic                                  csr_rdonly;
    logic                                  trap;
    logic [trap_cfg_pkg::trap_cause_w-1:0] trap_cause;
    logic [31:1]                           trap_pc;
    logic                                  insn_valid;
    logic [31:1]                           insn_pc;
    logic                                  mret;
    logic                                  exception;
    logic [31:2]                           trap_vector;
    logic [31:1]                           ret_epc;

    integer seed = 32'h4e54_109f;
    int     cycles = 0;

    trap_unit_top #(
        .hartid (hart_id),
        .irq_lo (irq_lo)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq),
        .csr_addr    (csr_addr),
        .csr_we      (csr_we),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .csr_exists  (csr_exists),
        .csr_rdonly  (csr_rdonly),
        .trap        (trap),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .insn_valid  (insn_valid),
        .insn_pc     (insn_pc),
        .mret        (mret),
        .exception   (exception),
        .trap_vector (trap_vector),
        .ret_epc     (ret_epc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("sim failed");
            $fatal(1, "Timeout: the tests did not finish within %0d cycles", timeout_cycles);
        end
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Expected mstatus word from its two fields.
    function automatic logic [31:0] mstatus_word(input logic en, input logic pen);
        rv_csr_pkg::csr_wdata_u u;
        u              = '0;
        u.mstatus.mie  = en;
        u.mstatus.mpie = pen;
        return u.raw;
    endfunction

    // Expected mcause word, flag and number.
    function automatic logic [31:0] mcause_word(input logic intr, input logic [4:0] no);
        rv_csr_pkg::csr_wdata_u u;
        u                  = '0;
        u.mcause.interrupt = intr;
        u.mcause.cause     = no;
        return u.raw;
    endfunction

    // One write, applied at the rising edge in between.
    task automatic csr_write(input rv_csr_pkg::csr_addr_t addr, input logic [31:0] data);
        @(negedge clk);
        csr_addr  = addr;
        csr_wdata = data;
        csr_we    = 1'b1;
        @(negedge clk);
        csr_we    = 1'b0;
    endtask

    task automatic read_expect(input string name, input rv_csr_pkg::csr_addr_t addr,
                               input logic [31:0] expected);
        @(negedge clk);
        csr_addr = addr;
        #1;
        compare(name, csr_rdata, expected);
    endtask

    task automatic reset_values();
        read_expect("mstatus", rv_csr_pkg::csr_mstatus, 32'h0);
        read_expect("mie", rv_csr_pkg::csr_mie, 32'h0);
        read_expect("mtvec", rv_csr_pkg::csr_mtvec, 32'h0);
        read_expect("mscratch", rv_csr_pkg::csr_mscratch, 32'h0);
        read_expect("mepc", rv_csr_pkg::csr_mepc, 32'h0);
        read_expect("mcause", rv_csr_pkg::csr_mcause, 32'h0);
        compare("exception", 32'(exception), 32'h0);
        compare("ret_epc", {ret_epc, 1'b0}, 32'h0);
        read_expect("misa", rv_csr_pkg::csr_misa, 32'h4000_1100);
        compare("misa exists", 32'(csr_exists), 32'h1);
        compare("misa rdonly", 32'(csr_rdonly), 32'h0);
        read_expect("mhartid", rv_csr_pkg::csr_mhartid, hart_id);
        compare("mhartid exists", 32'(csr_exists), 32'h1);
        compare("mhartid rdonly", 32'(csr_rdonly), 32'h1);
        // Custom range, nothing decoded there.
        @(negedge clk);
        csr_addr = 12'h7c0;
        #1;
        compare("unused exists", 32'(csr_exists), 32'h0);
    endtask

    task automatic write_readback();
        logic [31:0] w;
        for (int i = 0; i < 3; i++) begin
            w = $random(seed);
            csr_write(rv_csr_pkg::csr_mscratch, w);
            read_expect("mscratch", rv_csr_pkg::csr_mscratch, w);
        end
        w = $random(seed);
        csr_write(rv_csr_pkg::csr_mtvec, w);
        read_expect("mtvec", rv_csr_pkg::csr_mtvec, {w[31:2], 2'b00});
        w = $random(seed);
        csr_write(rv_csr_pkg::csr_mepc, w);
        read_expect("mepc", rv_csr_pkg::csr_mepc, {w[31:1], 1'b0});
        // Only MIE and MPIE stick.
        csr_write(rv_csr_pkg::csr_mstatus, 32'hffff_ffff);
        read_expect("mstatus", rv_csr_pkg::csr_mstatus, mstatus_word(1'b1, 1'b1));
        csr_write(rv_csr_pkg::csr_mstatus, 32'h0);
        w = $random(seed);
        csr_write(rv_csr_pkg::csr_mcause, w);
        read_expect("mcause", rv_csr_pkg::csr_mcause, mcause_word(w[31], w[4:0]));
        // Read-only and constant CSRs.
        csr_write(rv_csr_pkg::csr_mhartid, $random(seed));
        read_expect("mhartid", rv_csr_pkg::csr_mhartid, hart_id);
        csr_write(rv_csr_pkg::csr_medeleg, $random(seed));
        read_expect("medeleg", rv_csr_pkg::csr_medeleg, 32'h0);
    endtask

    task automatic trap_entry();
        logic [31:0] vec;
        logic [31:0] pc;
        vec = 32'h8000_0040;
        pc  = $random(seed);
        csr_write(rv_csr_pkg::csr_mtvec, vec);
        csr_write(rv_csr_pkg::csr_mstatus, mstatus_word(1'b1, 1'b0));
        @(negedge clk);
        trap       = 1'b1;
        trap_cause = 4'hb;
        trap_pc    = pc[31:1];
        #1;
        compare("exception", 32'(exception), 32'h1);
        compare("trap_vector", {trap_vector, 2'b00}, vec);
        @(negedge clk);
        trap = 1'b0;
        #1;
        compare("exception", 32'(exception), 32'h0);
        read_expect("mepc", rv_csr_pkg::csr_mepc, {pc[31:1], 1'b0});
        read_expect("mcause", rv_csr_pkg::csr_mcause, mcause_word(1'b0, 5'h0b));
        read_expect("mstatus", rv_csr_pkg::csr_mstatus, mstatus_word(1'b0, 1'b1));
    endtask

    task automatic irq_select();
        logic [31:0] mie_word;
        logic [31:0] lines;
        logic [31:0] pc;
        mie_word = (32'h1 << 18) | (32'h1 << 20) | (32'h1 << 25);
        lines    = (32'h1 << 17) | (32'h1 << 20) | (32'h1 << 25) | (32'h1 << 30);
        csr_write(rv_csr_pkg::csr_mstatus, 32'h0);
        csr_write(rv_csr_pkg::csr_mie, mie_word);
        @(negedge clk);
        irq = lines[31:irq_lo];
        read_expect("mip", rv_csr_pkg::csr_mip, lines & mie_word);
        // MIE up, then one idle cycle before an interrupt may be taken.
        csr_write(rv_csr_pkg::csr_mstatus, mstatus_word(1'b1, 1'b0));
        @(negedge clk);
        pc         = $random(seed);
        insn_valid = 1'b1;
        insn_pc    = pc[31:1];
        #1;
        compare("exception", 32'(exception), 32'h1);
        @(negedge clk);
        insn_valid = 1'b0;
        read_expect("mcause", rv_csr_pkg::csr_mcause, mcause_word(1'b1, 5'd20));
        read_expect("mepc", rv_csr_pkg::csr_mepc, {pc[31:1], 1'b0});
        read_expect("mstatus", rv_csr_pkg::csr_mstatus, mstatus_word(1'b0, 1'b1));
        // Line 20 masked off, so 25 is next.
        csr_write(rv_csr_pkg::csr_mie, mie_word & ~(32'h1 << 20));
        csr_write(rv_csr_pkg::csr_mstatus, mstatus_word(1'b1, 1'b0));
        @(negedge clk);
        pc         = $random(seed);
        insn_valid = 1'b1;
        insn_pc    = pc[31:1];
        #1;
        compare("exception", 32'(exception), 32'h1);
        @(negedge clk);
        insn_valid = 1'b0;
        irq        = '0;
        read_expect("mcause", rv_csr_pkg::csr_mcause, mcause_word(1'b1, 5'd25));
        read_expect("mepc", rv_csr_pkg::csr_mepc, {pc[31:1], 1'b0});
    endtask

    task automatic mask_rank();
        logic [31:0] lines;
        logic [31:0] pc;
        lines = 32'h1 << 22;
        csr_write(rv_csr_pkg::csr_mstatus, 32'h0);
        csr_write(rv_csr_pkg::csr_mie, lines);
        @(negedge clk);
        irq = lines[31:irq_lo];
        // Pending and enabled, but MIE is clear.
        @(negedge clk);
        insn_valid = 1'b1;
        insn_pc    = 31'h100;
        #1;
        compare("exception", 32'(exception), 32'h0);
        @(negedge clk);
        insn_valid = 1'b0;
        csr_write(rv_csr_pkg::csr_mstatus, mstatus_word(1'b1, 1'b0));
        // First cycle with MIE set.
        insn_valid = 1'b1;
        #1;
        compare("exception", 32'(exception), 32'h0);
        // Interrupt and trap in the same cycle.
        @(negedge clk);
        pc         = $random(seed);
        insn_pc    = pc[31:1];
        trap       = 1'b1;
        trap_cause = 4'h2;
        trap_pc    = ~pc[31:1];
        #1;
        compare("exception", 32'(exception), 32'h1);
        @(negedge clk);
        trap       = 1'b0;
        insn_valid = 1'b0;
        irq        = '0;
        read_expect("mcause", rv_csr_pkg::csr_mcause, mcause_word(1'b1, 5'd22));
        read_expect("mepc", rv_csr_pkg::csr_mepc, {pc[31:1], 1'b0});
    endtask

    task automatic mret_return();
        logic [31:0] pc;
        pc = $random(seed);
        csr_write(rv_csr_pkg::csr_mie, 32'h0);
        csr_write(rv_csr_pkg::csr_mstatus, mstatus_word(1'b1, 1'b0));
        @(negedge clk);
        trap       = 1'b1;
        trap_cause = 4'h3;
        trap_pc    = pc[31:1];
        #1;
        compare("exception", 32'(exception), 32'h1);
        @(negedge clk);
        trap = 1'b0;
        #1;
        compare("ret_epc", {ret_epc, 1'b0}, {pc[31:1], 1'b0});
        read_expect("mstatus", rv_csr_pkg::csr_mstatus, mstatus_word(1'b0, 1'b1));
        @(negedge clk);
        mret = 1'b1;
        @(negedge clk);
        mret = 1'b0;
        read_expect("mstatus", rv_csr_pkg::csr_mstatus, mstatus_word(1'b1, 1'b1));
        // Saved enable of zero comes back as zero.
        csr_write(rv_csr_pkg::csr_mstatus, mstatus_word(1'b1, 1'b0));
        @(negedge clk);
        mret = 1'b1;
        @(negedge clk);
        mret = 1'b0;
        read_expect("mstatus", rv_csr_pkg::csr_mstatus, mstatus_word(1'b0, 1'b0));
    endtask

    initial begin
        rst        = 1'b1;
        irq        = '0;
        csr_addr   = '0;
        csr_we     = 1'b0;
        csr_wdata  = '0;
        trap       = 1'b0;
        trap_cause = '0;
        trap_pc    = '0;
        insn_valid = 1'b0;
        insn_pc    = '0;
        mret       = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_values();
        write_readback();
        trap_entry();
        irq_select();
        mask_rank();
        mret_return();
        $display("sim passed");
        $finish;
    end

endmodule

//--- src.f
verilog/rv_csr_pkg.sv
verilog/trap_cfg_pkg.sv
verilog/irq_arbiter.sv
verilog/trap_dispatch.sv
verilog/csr_file.sv
verilog/trap_unit_top.sv
sim/trap_unit_checker.sv
sim/trap_unit_tb.sv

//--- Makefile
# Verilator build and run of the trap unit testbench.

VERILATOR ?= verilator
TOP       ?= trap_unit_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
